/* design/commit_macros.svh */
`ifndef COMMIT_MACROS_SVH
`define COMMIT_MACROS_SVH

// instructions per issued pair
`define COMMIT_LANES 2

`define COMMIT_XLEN 32
`define COMMIT_REG_W 5

// exception entry, BEV set
`define COMMIT_EXC_VECTOR 32'hbfc0_0380

`endif

/* design/commit_pkg.sv */
`include "commit_macros.svh"

package commit_pkg;

    typedef logic [`COMMIT_XLEN-1:0] word_t;
    typedef logic [`COMMIT_REG_W-1:0] reg_idx_t;
    typedef logic [`COMMIT_XLEN/8-1:0] byte_en_t;

    // access size, 3 unused
    typedef logic [1:0] mem_size_t;

    localparam mem_size_t SIZE_BYTE = 2'd0;
    localparam mem_size_t SIZE_HALF = 2'd1;
    localparam mem_size_t SIZE_WORD = 2'd2;

    // cp0 cause codes
    typedef logic [4:0] exc_code_t;

    localparam exc_code_t EXC_INT  = 5'd0;
    localparam exc_code_t EXC_ADEL = 5'd4;
    localparam exc_code_t EXC_ADES = 5'd5;
    localparam exc_code_t EXC_SYS  = 5'd8;

    // decoded operation set reaching commit
    typedef enum logic [3:0] {
        OP_NOP,
        OP_ALU,
        OP_LB,
        OP_LBU,
        OP_LH,
        OP_LHU,
        OP_LW,
        OP_SB,
        OP_SH,
        OP_SW,
        OP_SYSCALL,
        OP_ERET
    } op_t;

    typedef enum logic {
        PAIR_EMPTY,
        PAIR_HELD
    } pair_state_t;

endpackage

/* design/commit_latch.sv */
`include "commit_macros.svh"

module commit_latch (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     in_valid,
    input  logic                                     finish,
    input  commit_pkg::op_t      [`COMMIT_LANES-1:0] in_op,
    input  commit_pkg::word_t    [`COMMIT_LANES-1:0] in_pc,
    input  commit_pkg::word_t    [`COMMIT_LANES-1:0] in_result,
    input  commit_pkg::word_t    [`COMMIT_LANES-1:0] in_store_data,
    input  commit_pkg::reg_idx_t [`COMMIT_LANES-1:0] in_dest,
    output logic                                     stall,
    output logic                                     pair_valid,
    output commit_pkg::op_t      [`COMMIT_LANES-1:0] pair_op,
    output commit_pkg::word_t    [`COMMIT_LANES-1:0] pair_pc,
    output commit_pkg::word_t    [`COMMIT_LANES-1:0] pair_result,
    output commit_pkg::word_t    [`COMMIT_LANES-1:0] pair_store_data,
    output commit_pkg::reg_idx_t [`COMMIT_LANES-1:0] pair_dest
);

    import commit_pkg::*;

    pair_state_t state;
    logic        accept;

    assign pair_valid = (state == PAIR_HELD);

    // a held pair blocks new input until merge says it is done
    assign stall  = pair_valid & ~finish;
    assign accept = in_valid & ~stall;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= PAIR_EMPTY;
        end else begin
            case (state)
                PAIR_EMPTY: begin
                    if (accept) begin
                        state <= PAIR_HELD;
                    end
                end
                PAIR_HELD: begin
                    // finish cycle may take the next pair directly
                    if (finish && !accept) begin
                        state <= PAIR_EMPTY;
                    end
                end
                default: state <= PAIR_EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pair_op         <= in_op;
            pair_pc         <= in_pc;
            pair_result     <= in_result;
            pair_store_data <= in_store_data;
            pair_dest       <= in_dest;
        end
    end

endmodule

/* design/commit_lane.sv */
`include "commit_macros.svh"

module commit_lane (
    input  commit_pkg::op_t       op,
    input  commit_pkg::word_t     pc,
    input  commit_pkg::word_t     result,
    input  commit_pkg::word_t     store_data,
    input  commit_pkg::reg_idx_t  dest,
    input  commit_pkg::word_t     dmem_rdata,
    output logic                  exc_hit,
    output commit_pkg::exc_code_t exc_code,
    output logic                  is_eret,
    output logic                  mem_req,
    output logic                  mem_wt,
    output commit_pkg::word_t     mem_addr,
    output commit_pkg::byte_en_t  mem_be,
    output commit_pkg::word_t     mem_wdata,
    output logic                  wb_req,
    output commit_pkg::word_t     wb_data
);

    import commit_pkg::*;

    logic      is_load;
    logic      is_store;
    logic      is_sign;
    mem_size_t size;
    logic      misaligned;
    logic [1:0] off;
    logic [7:0]  rd_byte;
    logic [15:0] rd_half;
    word_t     load_data;

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        is_sign  = 1'b0;
        size     = SIZE_WORD;
        case (op)
            OP_LB:  begin is_load = 1'b1; is_sign = 1'b1; size = SIZE_BYTE; end
            OP_LBU: begin is_load = 1'b1; size = SIZE_BYTE; end
            OP_LH:  begin is_load = 1'b1; is_sign = 1'b1; size = SIZE_HALF; end
            OP_LHU: begin is_load = 1'b1; size = SIZE_HALF; end
            OP_LW:  begin is_load = 1'b1; end
            OP_SB:  begin is_store = 1'b1; size = SIZE_BYTE; end
            OP_SH:  begin is_store = 1'b1; size = SIZE_HALF; end
            OP_SW:  begin is_store = 1'b1; end
            default: ;
        endcase
    end

    assign off = result[1:0];
    assign misaligned = ((size == SIZE_HALF) && off[0]) ||
                        ((size == SIZE_WORD) && (off != 2'b00));

    always_comb begin
        exc_hit  = 1'b0;
        exc_code = EXC_INT;
        if ((is_load || is_store) && misaligned) begin
            exc_hit  = 1'b1;
            exc_code = is_load ? EXC_ADEL : EXC_ADES;
        end else if (op == OP_SYSCALL) begin
            exc_hit  = 1'b1;
            exc_code = EXC_SYS;
        end
    end

    assign is_eret  = (op == OP_ERET);
    assign mem_req  = (is_load || is_store) && !misaligned;
    assign mem_wt   = is_store;
    assign mem_addr = {result[`COMMIT_XLEN-1:2], 2'b00};

    // little endian lanes, data copied to every slot
    always_comb begin
        case (size)
            SIZE_BYTE: begin
                mem_wdata = {4{store_data[7:0]}};
                mem_be    = 4'b0001 << off;
            end
            SIZE_HALF: begin
                mem_wdata = {2{store_data[15:0]}};
                mem_be    = off[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                mem_wdata = store_data;
                mem_be    = 4'b1111;
            end
        endcase
    end

    assign rd_byte = dmem_rdata[{off, 3'b000} +: 8];
    assign rd_half = dmem_rdata[{off[1], 4'b0000} +: 16];

    always_comb begin
        case (size)
            SIZE_BYTE: load_data = {{(`COMMIT_XLEN-8){is_sign & rd_byte[7]}}, rd_byte};
            SIZE_HALF: load_data = {{(`COMMIT_XLEN-16){is_sign & rd_half[15]}}, rd_half};
            default:   load_data = dmem_rdata;
        endcase
    end

    // r0 is hardwired, never written
    assign wb_req = ((is_load && !misaligned) || (op == OP_ALU)) && (dest != '0);

    // ops without a result put their pc on the bus, handy in waves
    assign wb_data = is_load ? load_data : ((op == OP_ALU) ? result : pc);

endmodule

/* design/commit_merge.sv */
`include "commit_macros.svh"

module commit_merge (
    input  logic                                      pair_valid,
    input  logic                                      int_pending,
    input  logic                                      dmem_data_ok,
    input  commit_pkg::word_t                         cp0_epc,
    input  commit_pkg::word_t     [`COMMIT_LANES-1:0] pair_pc,
    input  logic                  [`COMMIT_LANES-1:0] lane_exc_hit,
    input  commit_pkg::exc_code_t [`COMMIT_LANES-1:0] lane_exc_code,
    input  logic                  [`COMMIT_LANES-1:0] lane_is_eret,
    input  logic                  [`COMMIT_LANES-1:0] lane_mem_req,
    input  logic                  [`COMMIT_LANES-1:0] lane_mem_wt,
    input  commit_pkg::word_t     [`COMMIT_LANES-1:0] lane_mem_addr,
    input  commit_pkg::byte_en_t  [`COMMIT_LANES-1:0] lane_mem_be,
    input  commit_pkg::word_t     [`COMMIT_LANES-1:0] lane_mem_wdata,
    input  logic                  [`COMMIT_LANES-1:0] lane_wb_req,
    output logic                                      finish,
    output logic                                      dmem_en,
    output logic                                      dmem_wt,
    output commit_pkg::word_t                         dmem_addr,
    output commit_pkg::byte_en_t                      dmem_be,
    output commit_pkg::word_t                         dmem_wdata,
    output logic                  [`COMMIT_LANES-1:0] wb_en,
    output logic                                      exc_valid,
    output commit_pkg::exc_code_t                     exc_code,
    output commit_pkg::word_t                         exc_epc,
    output logic                                      redirect_valid,
    output commit_pkg::word_t                         redirect_pc
);

    import commit_pkg::*;

    logic [`COMMIT_LANES-1:0] live;
    logic [`COMMIT_LANES-1:0] mem_live;
    logic                     mem_sel;
    logic                     old_exc;
    logic                     young_exc;
    logic                     take_exc;
    logic                     take_eret;

    // lane 1 is older and wins every conflict
    assign old_exc   = int_pending | lane_exc_hit[1];
    assign young_exc = lane_exc_hit[0] & ~lane_is_eret[1];

    assign live[1] = ~old_exc;
    assign live[0] = ~old_exc & ~lane_is_eret[1] & ~lane_exc_hit[0];

    assign take_exc  = old_exc | young_exc;

    // eret on either surviving lane returns to epc
    assign take_eret = ~old_exc & (lane_is_eret[1] | (live[0] & lane_is_eret[0]));

    // issue sends at most one memory op per pair
    assign mem_live = live & lane_mem_req;
    assign mem_sel  = mem_live[1];

    assign dmem_en    = pair_valid & (|mem_live);
    assign dmem_wt    = dmem_en & lane_mem_wt[mem_sel];
    assign dmem_addr  = lane_mem_addr[mem_sel];
    assign dmem_be    = lane_mem_be[mem_sel];
    assign dmem_wdata = lane_mem_wdata[mem_sel];

    // memory pairs end on the data_ok pulse
    assign finish = pair_valid & (~(|mem_live) | dmem_data_ok);

    assign wb_en = {`COMMIT_LANES{finish}} & live & lane_wb_req;

    assign exc_valid = finish & take_exc;

    always_comb begin
        if (int_pending) begin
            exc_code = EXC_INT;
        end else if (lane_exc_hit[1]) begin
            exc_code = lane_exc_code[1];
        end else begin
            exc_code = lane_exc_code[0];
        end
    end

    assign exc_epc = old_exc ? pair_pc[1] : pair_pc[0];

    assign redirect_valid = finish & (take_exc | take_eret);
    assign redirect_pc    = take_exc ? `COMMIT_EXC_VECTOR : cp0_epc;

endmodule

/* design/commit_top.sv */
`include "commit_macros.svh"

module commit_top (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      in_valid,
    input  commit_pkg::op_t       [`COMMIT_LANES-1:0] in_op,
    input  commit_pkg::word_t     [`COMMIT_LANES-1:0] in_pc,
    input  commit_pkg::word_t     [`COMMIT_LANES-1:0] in_result,
    input  commit_pkg::word_t     [`COMMIT_LANES-1:0] in_store_data,
    input  commit_pkg::reg_idx_t  [`COMMIT_LANES-1:0] in_dest,
    input  logic                                      int_pending,
    input  commit_pkg::word_t                         cp0_epc,
    output logic                                      stall,
    output logic                                      dmem_en,
    output logic                                      dmem_wt,
    output commit_pkg::word_t                         dmem_addr,
    output commit_pkg::byte_en_t                      dmem_be,
    output commit_pkg::word_t                         dmem_wdata,
    input  commit_pkg::word_t                         dmem_rdata,
    input  logic                                      dmem_data_ok,
    output logic                  [`COMMIT_LANES-1:0] wb_en,
    output commit_pkg::reg_idx_t  [`COMMIT_LANES-1:0] wb_dest,
    output commit_pkg::word_t     [`COMMIT_LANES-1:0] wb_data,
    output logic                                      exc_valid,
    output commit_pkg::exc_code_t                     exc_code,
    output commit_pkg::word_t                         exc_epc,
    output logic                                      redirect_valid,
    output commit_pkg::word_t                         redirect_pc
);

    import commit_pkg::*;

    logic                           pair_valid;
    logic                           finish;
    op_t       [`COMMIT_LANES-1:0] pair_op;
    word_t     [`COMMIT_LANES-1:0] pair_pc;
    word_t     [`COMMIT_LANES-1:0] pair_result;
    word_t     [`COMMIT_LANES-1:0] pair_store_data;
    reg_idx_t  [`COMMIT_LANES-1:0] pair_dest;

    logic      [`COMMIT_LANES-1:0] lane_exc_hit;
    exc_code_t [`COMMIT_LANES-1:0] lane_exc_code;
    logic      [`COMMIT_LANES-1:0] lane_is_eret;
    logic      [`COMMIT_LANES-1:0] lane_mem_req;
    logic      [`COMMIT_LANES-1:0] lane_mem_wt;
    word_t     [`COMMIT_LANES-1:0] lane_mem_addr;
    byte_en_t  [`COMMIT_LANES-1:0] lane_mem_be;
    word_t     [`COMMIT_LANES-1:0] lane_mem_wdata;
    logic      [`COMMIT_LANES-1:0] lane_wb_req;

    assign wb_dest = pair_dest;

    commit_latch u_latch (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .finish          (finish),
        .in_op           (in_op),
        .in_pc           (in_pc),
        .in_result       (in_result),
        .in_store_data   (in_store_data),
        .in_dest         (in_dest),
        .stall           (stall),
        .pair_valid      (pair_valid),
        .pair_op         (pair_op),
        .pair_pc         (pair_pc),
        .pair_result     (pair_result),
        .pair_store_data (pair_store_data),
        .pair_dest       (pair_dest)
    );

    genvar i;
    generate
        for (i = 0; i < `COMMIT_LANES; i++) begin : g_lane
            commit_lane u_lane (
                .op         (pair_op[i]),
                .pc         (pair_pc[i]),
                .result     (pair_result[i]),
                .store_data (pair_store_data[i]),
                .dest       (pair_dest[i]),
                .dmem_rdata (dmem_rdata),
                .exc_hit    (lane_exc_hit[i]),
                .exc_code   (lane_exc_code[i]),
                .is_eret    (lane_is_eret[i]),
                .mem_req    (lane_mem_req[i]),
                .mem_wt     (lane_mem_wt[i]),
                .mem_addr   (lane_mem_addr[i]),
                .mem_be     (lane_mem_be[i]),
                .mem_wdata  (lane_mem_wdata[i]),
                .wb_req     (lane_wb_req[i]),
                .wb_data    (wb_data[i])
            );
        end
    endgenerate

    commit_merge u_merge (
        .pair_valid     (pair_valid),
        .int_pending    (int_pending),
        .dmem_data_ok   (dmem_data_ok),
        .cp0_epc        (cp0_epc),
        .pair_pc        (pair_pc),
        .lane_exc_hit   (lane_exc_hit),
        .lane_exc_code  (lane_exc_code),
        .lane_is_eret   (lane_is_eret),
        .lane_mem_req   (lane_mem_req),
        .lane_mem_wt    (lane_mem_wt),
        .lane_mem_addr  (lane_mem_addr),
        .lane_mem_be    (lane_mem_be),
        .lane_mem_wdata (lane_mem_wdata),
        .lane_wb_req    (lane_wb_req),
        .finish         (finish),
        .dmem_en        (dmem_en),
        .dmem_wt        (dmem_wt),
        .dmem_addr      (dmem_addr),
        .dmem_be        (dmem_be),
        .dmem_wdata     (dmem_wdata),
        .wb_en          (wb_en),
        .exc_valid      (exc_valid),
        .exc_code       (exc_code),
        .exc_epc        (exc_epc),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

/* verification/commit_chk.sv */
`include "commit_macros.svh"

module commit_chk (
    input logic                                      clk,
    input logic                                      rst_n,
    input logic                                      stall,
    input logic                                      pair_valid,
    input logic                                      finish,
    input logic                                      dmem_en,
    input logic                                      dmem_wt,
    input commit_pkg::word_t                         dmem_addr,
    input commit_pkg::byte_en_t                      dmem_be,
    input commit_pkg::word_t                         dmem_wdata,
    input logic                                      dmem_data_ok,
    input logic                  [`COMMIT_LANES-1:0] lane_mem_req,
    input logic                  [`COMMIT_LANES-1:0] wb_en,
    input logic                                      exc_valid,
    input logic                                      redirect_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    // request held steady until the memory answers
    a_mem_stable: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_en && !dmem_data_ok |=> dmem_en && $stable({dmem_wt, dmem_addr, dmem_be, dmem_wdata}))
        else $error("dmem request changed before data_ok");

    a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !finish |-> !(|wb_en) && !exc_valid && !redirect_valid)
        else $error("result strobe outside finish cycle");

    a_one_mem: assert property (@(posedge clk) disable iff (!rst_n)
        pair_valid |-> $countones(lane_mem_req) <= 1)
        else $error("two memory lanes in one pair");

    a_reset: assert property (@(posedge clk)
        !rst_n |=> !stall && !dmem_en && !(|wb_en) && !exc_valid && !redirect_valid)
        else $error("outputs active after reset");

endmodule

bind commit_top commit_chk chk_i (.*);

/* verification/commit_tb.sv */
`include "commit_macros.svh"

module commit_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import commit_pkg::*;

    logic                              clk;
    logic                              rst_n;
    logic                              in_valid;
    op_t      [`COMMIT_LANES-1:0]      in_op;
    word_t    [`COMMIT_LANES-1:0]      in_pc;
    word_t    [`COMMIT_LANES-1:0]      in_result;
    word_t    [`COMMIT_LANES-1:0]      in_store_data;
    reg_idx_t [`COMMIT_LANES-1:0]      in_dest;
    logic                              int_pending;
    word_t                             cp0_epc;
    logic                              stall;
    logic                              dmem_en;
    logic                              dmem_wt;
    word_t                             dmem_addr;
    byte_en_t                          dmem_be;
    word_t                             dmem_wdata;
    word_t                             dmem_rdata;
    logic                              dmem_data_ok;
    logic     [`COMMIT_LANES-1:0]      wb_en;
    reg_idx_t [`COMMIT_LANES-1:0]      wb_dest;
    word_t    [`COMMIT_LANES-1:0]      wb_data;
    logic                              exc_valid;
    exc_code_t                         exc_code;
    word_t                             exc_epc;
    logic                              redirect_valid;
    word_t                             redirect_pc;

    logic [31:0] seed = 32'hdee6_d714;
    logic [31:0] lat_seed = ~32'hdee6_d714;
    word_t       mem [64];
    word_t       ref_mem [64];
    logic        busy;
    int          wait_cnt;

    commit_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t fill_word(input int i);
        return (i * 32'h9e37_79b9) ^ 32'h5a5a_a5a5;
    endfunction

    task automatic fail_now();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            fail_now();
        end
    endtask

    task automatic check_code(input string name, input exc_code_t exp, input exc_code_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            fail_now();
        end
    endtask

    task automatic check_dest(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            fail_now();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
            fail_now();
        end
    endtask

    task automatic check_be(input string name, input byte_en_t exp, input byte_en_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
            fail_now();
        end
    endtask

    function automatic op_t pick_op(input logic [3:0] r);
        case (r)
            4'd0:    return OP_NOP;
            4'd5:    return OP_LB;
            4'd6:    return OP_LBU;
            4'd7:    return OP_LH;
            4'd8:    return OP_LHU;
            4'd9:    return OP_LW;
            4'd10:   return OP_SB;
            4'd11:   return OP_SH;
            4'd12:   return OP_SW;
            4'd13:   return OP_SYSCALL;
            4'd14:   return OP_ERET;
            default: return OP_ALU;
        endcase
    endfunction

    function automatic logic is_ld(input op_t o);
        return (o == OP_LB) || (o == OP_LBU) || (o == OP_LH) || (o == OP_LHU) || (o == OP_LW);
    endfunction

    function automatic logic is_st(input op_t o);
        return (o == OP_SB) || (o == OP_SH) || (o == OP_SW);
    endfunction

    function automatic logic misaligned(input op_t o, input logic [1:0] a);
        if ((o == OP_LH) || (o == OP_LHU) || (o == OP_SH))
            return a[0];
        if ((o == OP_LW) || (o == OP_SW))
            return a != 2'b00;
        return 1'b0;
    endfunction

    // little endian pick from the addressed word
    function automatic word_t load_value(input op_t o, input word_t w, input logic [1:0] a);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[8*a +: 8];
        h = a[1] ? w[31:16] : w[15:0];
        case (o)
            OP_LB:   return {{24{b[7]}}, b};
            OP_LBU:  return {24'h0, b};
            OP_LH:   return {{16{h[15]}}, h};
            OP_LHU:  return {16'h0, h};
            default: return w;
        endcase
    endfunction

    // bytes of the word covered by a store at this offset
    function automatic byte_en_t store_be(input op_t o, input logic [1:0] a);
        byte_en_t be;
        for (int k = 0; k < 4; k++) begin
            case (o)
                OP_SB:   be[k] = (k == a);
                OP_SH:   be[k] = (k[1] == a[1]);
                default: be[k] = 1'b1;
            endcase
        end
        return be;
    endfunction

    // store data repeated in every byte or half slot
    function automatic word_t store_word(input op_t o, input word_t d);
        case (o)
            OP_SB:   return {4{d[7:0]}};
            OP_SH:   return {2{d[15:0]}};
            default: return d;
        endcase
    endfunction

    // memory responder with 0 to 3 wait cycles
    always @(posedge clk) begin
        if (!rst_n) begin
            dmem_data_ok <= 1'b0;
            busy = 1'b0;
        end else if (dmem_data_ok) begin
            dmem_data_ok <= 1'b0;
            if (dmem_wt) begin
                for (int k = 0; k < 4; k++) begin
                    if (dmem_be[k])
                        mem[dmem_addr[7:2]][8*k +: 8] = dmem_wdata[8*k +: 8];
                end
            end
        end else if (dmem_en) begin
            if (!busy) begin
                busy = 1'b1;
                lat_seed = lcg(lat_seed);
                wait_cnt = int'(lat_seed[31:30]);
            end
            if (wait_cnt == 0) begin
                busy = 1'b0;
                dmem_data_ok <= 1'b1;
                dmem_rdata <= mem[dmem_addr[7:2]];
            end else begin
                wait_cnt = wait_cnt - 1;
            end
        end
    end

    initial begin
        op_t       o [2];
        word_t     res [2];
        word_t     sdat [2];
        reg_idx_t  dst [2];
        word_t     pc [2];
        logic      e [2];
        logic      live [2];
        logic      mem_ok [2];
        exc_code_t c [2];
        logic      old_exc;
        logic      exp_exc;
        logic      exp_eret;
        int        ml;
        int        cnt;
        word_t     exp_wb;
        logic      exp_en;

        rst_n = 1'b0;
        in_valid = 1'b0;
        in_op = {OP_NOP, OP_NOP};
        in_pc = '0;
        in_result = '0;
        in_store_data = '0;
        in_dest = '0;
        int_pending = 1'b0;
        cp0_epc = '0;
        dmem_rdata = '0;
        dmem_data_ok = 1'b0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = fill_word(i);
            ref_mem[i] = fill_word(i);
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
        end while (stall && cnt < 50);
        if (stall) begin
            $display("stall did not drop after reset within 50 cycles");
            fail_now();
        end

        for (int n = 0; n < 400; n++) begin
            @(posedge clk);
            for (int l = 0; l < 2; l++) begin
                seed = lcg(seed);
                o[l] = pick_op(seed[31:28]);
                dst[l] = seed[20:16];
                seed = lcg(seed);
                res[l] = seed;
                seed = lcg(seed);
                // mostly aligned addresses
                if (seed[31:29] != 3'd0)
                    res[l][1:0] = (o[l] == OP_LH || o[l] == OP_LHU || o[l] == OP_SH) ?
                                  {res[l][1], 1'b0} : (is_ld(o[l]) || is_st(o[l])) &&
                                  o[l] != OP_LB && o[l] != OP_LBU && o[l] != OP_SB ?
                                  2'b00 : res[l][1:0];
                sdat[l] = lcg(seed);
                pc[l] = {seed[23:2], 2'b00} + l * 4;
            end
            // issue never pairs two memory ops
            if ((is_ld(o[1]) || is_st(o[1])) && (is_ld(o[0]) || is_st(o[0])))
                o[0] = OP_ALU;
            seed = lcg(seed);
            in_valid <= 1'b1;
            in_op <= {o[1], o[0]};
            in_pc <= {pc[1], pc[0]};
            in_result <= {res[1], res[0]};
            in_store_data <= {sdat[1], sdat[0]};
            in_dest <= {dst[1], dst[0]};
            int_pending <= (seed[31:28] == 4'd0);
            cp0_epc <= lcg(seed);
            @(posedge clk);
            in_valid <= 1'b0;
            @(negedge clk);

            for (int l = 0; l < 2; l++) begin
                mem_ok[l] = (is_ld(o[l]) || is_st(o[l])) && !misaligned(o[l], res[l][1:0]);
                e[l] = ((is_ld(o[l]) || is_st(o[l])) && !mem_ok[l]) || o[l] == OP_SYSCALL;
                c[l] = (o[l] == OP_SYSCALL) ? EXC_SYS : (is_ld(o[l]) ? EXC_ADEL : EXC_ADES);
            end
            old_exc = int_pending || e[1];
            live[1] = !old_exc;
            live[0] = !old_exc && o[1] != OP_ERET && !e[0];
            exp_exc = old_exc || (e[0] && o[1] != OP_ERET);
            exp_eret = !old_exc && (o[1] == OP_ERET || (live[0] && o[0] == OP_ERET));
            ml = (live[1] && mem_ok[1]) ? 1 : ((live[0] && mem_ok[0]) ? 0 : -1);

            if (ml >= 0) begin
                cnt = 0;
                while (!dmem_data_ok && cnt < 50) begin
                    check_bit("stall while memory busy", 1'b1, stall);
                    @(negedge clk);
                    cnt++;
                end
                if (!dmem_data_ok) begin
                    $display("memory access did not finish within 50 cycles");
                    fail_now();
                end
                check_bit("dmem_wt", is_st(o[ml]), dmem_wt);
                check_word("dmem_addr", {res[ml][31:2], 2'b00}, dmem_addr);
                if (is_st(o[ml])) begin
                    check_be("dmem_be", store_be(o[ml], res[ml][1:0]), dmem_be);
                    check_word("dmem_wdata", store_word(o[ml], sdat[ml]), dmem_wdata);
                end
            end else begin
                check_bit("no dmem_en", 1'b0, dmem_en);
            end
            check_bit("stall at finish", 1'b0, stall);

            for (int l = 0; l < 2; l++) begin
                exp_en = live[l] && (o[l] == OP_ALU || (is_ld(o[l]) && mem_ok[l])) && dst[l] != 0;
                check_bit($sformatf("wb_en lane %0d", l), exp_en, wb_en[l]);
                if (exp_en) begin
                    exp_wb = (o[l] == OP_ALU) ? res[l] :
                             load_value(o[l], ref_mem[res[l][7:2]], res[l][1:0]);
                    check_word($sformatf("wb_data lane %0d", l), exp_wb, wb_data[l]);
                    check_dest($sformatf("wb_dest lane %0d", l), dst[l], wb_dest[l]);
                end
            end
            check_bit("exc_valid", exp_exc, exc_valid);
            if (exp_exc) begin
                check_code("exc_code", int_pending ? EXC_INT : (e[1] ? c[1] : c[0]), exc_code);
                check_word("exc_epc", old_exc ? pc[1] : pc[0], exc_epc);
            end
            check_bit("redirect_valid", exp_exc || exp_eret, redirect_valid);
            if (exp_exc || exp_eret)
                check_word("redirect_pc", exp_exc ? `COMMIT_EXC_VECTOR : cp0_epc, redirect_pc);

            if (ml >= 0 && is_st(o[ml])) begin
                case (o[ml])
                    OP_SB: ref_mem[res[ml][7:2]][8*res[ml][1:0] +: 8] = sdat[ml][7:0];
                    OP_SH: ref_mem[res[ml][7:2]][16*res[ml][1] +: 16] = sdat[ml][15:0];
                    default: ref_mem[res[ml][7:2]] = sdat[ml];
                endcase
            end
        end

        $display("test passed");
        $finish;
    end

endmodule

/* src.f */
+incdir+design
design/commit_pkg.sv
design/commit_latch.sv
design/commit_lane.sv
design/commit_merge.sv
design/commit_top.sv
verification/commit_chk.sv
verification/commit_tb.sv

/* run.sh */
#!/bin/sh
# build and run the commit stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f src.f --top-module commit_tb \
    --Mdir obj_dir -o Vcommit_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vcommit_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^test passed$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
